// ==== rtl/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// word-addressed instruction memory
`define CPU_IM_AW 10

// byte-addressed data memory
`define CPU_DM_AW 12

// register file geometry
`define CPU_NREGS 32
`define CPU_RAW 5

`endif

// ==== rtl/cpu_pkg.sv ====
package cpu_pkg;

	typedef enum logic [5:0] {
		ALU_R = 6'b100000,
		ADDI  = 6'b101000,
		ORI   = 6'b101100,
		MOVI  = 6'b100010,
		LWI   = 6'b000010,
		SWI   = 6'b001010,
		BR    = 6'b100110,
		J     = 6'b100100
	} opcode_e;

	// register-form sub-opcodes
	typedef enum logic [4:0] {
		SUB_ADD   = 5'b00000,
		SUB_SUB   = 5'b00001,
		SUB_AND   = 5'b00010,
		SUB_XOR   = 5'b00011,
		SUB_OR    = 5'b00100,
		SUB_SLLI  = 5'b01000,
		SUB_SRLI  = 5'b01001,
		SUB_ROTRI = 5'b01011
	} alu_sub_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLL,
		ALU_SRL,
		ALU_ROR
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_NONE,
		WB_ALU,
		WB_MEM,
		WB_IMM
	} wb_src_e;

	typedef struct packed {
		logic       rsvd;
		opcode_e    op;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [4:0] shamt;
		alu_sub_e   sub;
	} instr_r_t;

	// branches use imm[14] as the not-equal select
	typedef struct packed {
		logic        rsvd;
		opcode_e     op;
		logic [4:0]  rt;
		logic [4:0]  ra;
		logic [14:0] imm;
	} instr_i_t;

	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

endpackage

// ==== rtl/instruction_decoder.sv ====
`include "cpu_cfg.svh"

module instruction_decoder import cpu_pkg::*; (
	input  instr_u              instruction,
	output logic [`CPU_RAW-1:0] ra_addr,
	output logic [`CPU_RAW-1:0] rb_addr,
	output logic [`CPU_RAW-1:0] rt_addr,
	output alu_op_e             alu_op,
	output logic [31:0]         imm_ext,
	output logic                use_imm,
	output logic                mem_read,
	output logic                mem_write,
	output logic                is_branch,
	output logic                branch_ne,
	output logic                is_jump,
	output wb_src_e             wb_src
);

	logic [31:0] mem_off;

	// rt and ra sit at the same bits in both views
	assign rt_addr = instruction.i.rt;
	assign ra_addr = instruction.i.ra;

	// word offset turned into a byte offset
	assign mem_off = {{15{instruction.i.imm[14]}}, instruction.i.imm, 2'b00};

	always_comb begin
		rb_addr   = instruction.r.rb;
		alu_op    = ALU_ADD;
		imm_ext   = '0;
		use_imm   = 1'b0;
		mem_read  = 1'b0;
		mem_write = 1'b0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		is_jump   = 1'b0;
		wb_src    = WB_NONE;
		case (instruction.i.op)
			ALU_R: begin
				wb_src = WB_ALU;
				case (instruction.r.sub)
					SUB_ADD:   alu_op = ALU_ADD;
					SUB_SUB:   alu_op = ALU_SUB;
					SUB_AND:   alu_op = ALU_AND;
					SUB_OR:    alu_op = ALU_OR;
					SUB_XOR:   alu_op = ALU_XOR;
					SUB_SLLI:  alu_op = ALU_SLL;
					SUB_SRLI:  alu_op = ALU_SRL;
					SUB_ROTRI: alu_op = ALU_ROR;
					default:   wb_src = WB_NONE;
				endcase
			end
			ADDI: begin
				use_imm = 1'b1;
				imm_ext = {{17{instruction.i.imm[14]}}, instruction.i.imm};
				wb_src  = WB_ALU;
			end
			ORI: begin
				alu_op  = ALU_OR;
				use_imm = 1'b1;
				imm_ext = {17'b0, instruction.i.imm};
				wb_src  = WB_ALU;
			end
			MOVI: begin
				imm_ext = {{12{instruction[19]}}, instruction[19:0]};
				wb_src  = WB_IMM;
			end
			LWI: begin
				use_imm  = 1'b1;
				imm_ext  = mem_off;
				mem_read = 1'b1;
				wb_src   = WB_MEM;
			end
			SWI: begin
				// store data comes out of the second read port
				rb_addr   = instruction.i.rt;
				use_imm   = 1'b1;
				imm_ext   = mem_off;
				mem_write = 1'b1;
			end
			BR: begin
				rb_addr   = instruction.i.rt;
				is_branch = 1'b1;
				branch_ne = instruction.i.imm[14];
				imm_ext   = {{18{instruction.i.imm[13]}}, instruction.i.imm[13:0]};
			end
			J: begin
				is_jump = 1'b1;
				imm_ext = {{8{instruction[23]}}, instruction[23:0]};
			end
			default: begin
				wb_src = WB_NONE;
			end
		endcase
	end

endmodule

// ==== rtl/regfile.sv ====
`include "cpu_cfg.svh"

module regfile (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`CPU_RAW-1:0] ra_addr,
	input  logic [`CPU_RAW-1:0] rb_addr,
	output logic [31:0]         ra_data,
	output logic [31:0]         rb_data,
	input  logic                we,
	input  logic [`CPU_RAW-1:0] wa,
	input  logic [31:0]         wd
);

	logic [31:0] regs [`CPU_NREGS];

	// r0 is hardwired and write-through covers the retiring value
	function automatic logic [31:0] read_port(input logic [`CPU_RAW-1:0] addr);
		if (addr == '0)
			return '0;
		else if (we && wa == addr)
			return wd;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < `CPU_NREGS; k++)
				regs[k] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	assign ra_data = read_port(ra_addr);
	assign rb_data = read_port(rb_addr);

endmodule

// ==== rtl/alu.sv ====
module alu import cpu_pkg::*; (
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [4:0]  shamt,
	input  alu_op_e     op,
	output logic [31:0] result,
	output logic        equal,
	output logic        overflow
);

	logic [31:0] sum;
	logic [31:0] diff;
	logic [63:0] rot;

	assign sum   = a + b;
	assign diff  = a - b;
	assign equal = (a == b);

	// rotate right by shifting the doubled word
	assign rot = {a, a} >> shamt;

	always_comb begin
		overflow = 1'b0;
		case (op)
			ALU_ADD: begin
				result   = sum;
				overflow = (a[31] == b[31]) && (sum[31] != a[31]);
			end
			ALU_SUB: begin
				result   = diff;
				overflow = (a[31] != b[31]) && (diff[31] != a[31]);
			end
			ALU_AND: begin
				result = a & b;
			end
			ALU_OR: begin
				result = a | b;
			end
			ALU_XOR: begin
				result = a ^ b;
			end
			ALU_SLL: begin
				result = a << shamt;
			end
			ALU_SRL: begin
				result = a >> shamt;
			end
			ALU_ROR: begin
				result = rot[31:0];
			end
			default: begin
				result = sum;
			end
		endcase
	end

endmodule

// ==== rtl/branch_unit.sv ====
`include "cpu_cfg.svh"

module branch_unit (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  valid,
	input  logic                  is_branch,
	input  logic                  branch_ne,
	input  logic                  is_jump,
	input  logic                  equal,
	input  logic [`CPU_IM_AW-1:0] ex_pc,
	input  logic [31:0]           offset,
	output logic [`CPU_IM_AW-1:0] pc,
	output logic                  redirect
);

	logic                  taken;
	logic [`CPU_IM_AW-1:0] target;

	assign taken    = is_branch && (equal != branch_ne);
	assign redirect = valid && (is_jump || taken);

	// word offset relative to the branch itself
	assign target = ex_pc + offset[`CPU_IM_AW-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (redirect)
			pc <= target;
		else
			pc <= pc + 1'b1;
	end

endmodule

// ==== rtl/pipe_regs.sv ====
`include "cpu_cfg.svh"

module pipe_regs import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  redirect,
	// fetch
	input  instr_u                if_instr,
	input  logic [`CPU_IM_AW-1:0] if_pc,
	output instr_u                id_instr,
	output logic [`CPU_IM_AW-1:0] id_pc,
	output logic                  id_valid,
	// decode
	input  alu_op_e               id_alu_op,
	input  logic [31:0]           id_imm_ext,
	input  logic [31:0]           id_ra_data,
	input  logic [31:0]           id_rb_data,
	input  logic [`CPU_RAW-1:0]   id_rt_addr,
	input  logic                  id_use_imm,
	input  logic                  id_mem_read,
	input  logic                  id_mem_write,
	input  logic                  id_is_branch,
	input  logic                  id_branch_ne,
	input  logic                  id_is_jump,
	input  wb_src_e               id_wb_src,
	output logic                  ex_valid,
	output logic [`CPU_IM_AW-1:0] ex_pc,
	output alu_op_e               ex_alu_op,
	output logic [4:0]            ex_shamt,
	output logic [31:0]           ex_imm_ext,
	output logic [31:0]           ex_ra_data,
	output logic [31:0]           ex_rb_data,
	output logic                  ex_use_imm,
	output logic                  ex_is_branch,
	output logic                  ex_branch_ne,
	output logic                  ex_is_jump,
	// execute
	input  logic [31:0]           ex_alu_result,
	input  logic                  ex_overflow,
	output logic                  mem_valid,
	output logic [31:0]           mem_alu_result,
	output logic [31:0]           mem_store_data,
	output logic [31:0]           mem_imm_ext,
	output logic [`CPU_RAW-1:0]   mem_rt_addr,
	output wb_src_e               mem_wb_src,
	output logic                  mem_read,
	output logic                  mem_write,
	output logic                  mem_overflow,
	output logic                  mem_ovf_update
);

	logic [`CPU_RAW-1:0] ex_rt_addr;
	logic                ex_mem_read;
	logic                ex_mem_write;
	wb_src_e             ex_wb_src;

	// redirect kills the slots in fetch and decode
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_valid       <= 1'b0;
			ex_valid       <= 1'b0;
			ex_mem_read    <= 1'b0;
			ex_mem_write   <= 1'b0;
			ex_is_branch   <= 1'b0;
			ex_branch_ne   <= 1'b0;
			ex_is_jump     <= 1'b0;
			ex_wb_src      <= WB_NONE;
			mem_valid      <= 1'b0;
			mem_read       <= 1'b0;
			mem_write      <= 1'b0;
			mem_wb_src     <= WB_NONE;
			mem_ovf_update <= 1'b0;
		end else begin
			id_valid       <= !redirect;
			ex_valid       <= id_valid && !redirect;
			ex_mem_read    <= id_mem_read;
			ex_mem_write   <= id_mem_write;
			ex_is_branch   <= id_is_branch;
			ex_branch_ne   <= id_branch_ne;
			ex_is_jump     <= id_is_jump;
			ex_wb_src      <= id_wb_src;
			mem_valid      <= ex_valid;
			mem_read       <= ex_valid && ex_mem_read;
			mem_write      <= ex_valid && ex_mem_write;
			mem_wb_src     <= ex_wb_src;
			// only add, sub and addi touch the flag
			mem_ovf_update <= ex_valid && ex_wb_src == WB_ALU &&
				(ex_alu_op == ALU_ADD || ex_alu_op == ALU_SUB);
		end
	end

	always_ff @(posedge clk) begin
		id_instr       <= if_instr;
		id_pc          <= if_pc;
		ex_pc          <= id_pc;
		ex_alu_op      <= id_alu_op;
		ex_shamt       <= id_instr.r.shamt;
		ex_imm_ext     <= id_imm_ext;
		ex_ra_data     <= id_ra_data;
		ex_rb_data     <= id_rb_data;
		ex_rt_addr     <= id_rt_addr;
		ex_use_imm     <= id_use_imm;
		mem_alu_result <= ex_alu_result;
		mem_store_data <= ex_rb_data;
		mem_imm_ext    <= ex_imm_ext;
		mem_rt_addr    <= ex_rt_addr;
		mem_overflow   <= ex_overflow;
	end

endmodule

// ==== rtl/writeback_stage.sv ====
`include "cpu_cfg.svh"

module writeback_stage import cpu_pkg::*; (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                valid,
	input  wb_src_e             wb_src,
	input  logic [`CPU_RAW-1:0] rt_addr,
	input  logic [31:0]         alu_result,
	input  logic [31:0]         imm_ext,
	input  logic [31:0]         mem_data,
	input  logic                ovf_update,
	input  logic                overflow,
	output logic                we,
	output logic [`CPU_RAW-1:0] wa,
	output logic [31:0]         wd,
	output logic                alu_overflow
);

	logic        wb_valid;
	wb_src_e     wb_sel;
	logic [31:0] wb_alu;
	logic [31:0] wb_imm;
	logic [31:0] wb_mem;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_valid     <= 1'b0;
			wb_sel       <= WB_NONE;
			alu_overflow <= 1'b0;
		end else begin
			wb_valid <= valid;
			wb_sel   <= wb_src;
			// sticky until the next add, sub or addi
			if (ovf_update)
				alu_overflow <= overflow;
		end
	end

	always_ff @(posedge clk) begin
		wa     <= rt_addr;
		wb_alu <= alu_result;
		wb_imm <= imm_ext;
		wb_mem <= mem_data;
	end

	assign we = wb_valid && wb_sel != WB_NONE;

	always_comb begin
		case (wb_sel)
			WB_MEM:  wd = wb_mem;
			WB_IMM:  wd = wb_imm;
			default: wd = wb_alu;
		endcase
	end

endmodule

// ==== rtl/cpu_top.sv ====
`include "cpu_cfg.svh"

module cpu_top import cpu_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [31:0]           instruction,
	output logic                  im_read,
	output logic [`CPU_IM_AW-1:0] im_address,
	output logic                  dm_read,
	output logic                  dm_write,
	output logic [`CPU_DM_AW-1:0] dm_address,
	output logic [31:0]           dm_wdata,
	input  logic [31:0]           dm_rdata,
	output logic                  alu_overflow
);

	logic                  redirect;
	instr_u                id_instr;
	logic [`CPU_IM_AW-1:0] id_pc, ex_pc;
	logic                  id_valid, ex_valid, mem_valid;
	logic [`CPU_RAW-1:0]   id_ra_addr, id_rb_addr, id_rt_addr, mem_rt_addr;
	alu_op_e               id_alu_op, ex_alu_op;
	wb_src_e               id_wb_src, mem_wb_src;
	logic [31:0]           id_imm_ext, id_ra_data, id_rb_data;
	logic                  id_use_imm, id_mem_read, id_mem_write;
	logic                  id_is_branch, id_branch_ne, id_is_jump;
	logic [4:0]            ex_shamt;
	logic [31:0]           ex_imm_ext, ex_ra_data, ex_rb_data;
	logic [31:0]           ex_alu_b, ex_alu_result;
	logic                  ex_use_imm, ex_is_branch, ex_branch_ne, ex_is_jump;
	logic                  ex_equal, ex_overflow;
	logic [31:0]           mem_alu_result, mem_store_data, mem_imm_ext;
	logic                  mem_overflow, mem_ovf_update;
	logic                  rf_we;
	logic [`CPU_RAW-1:0]   rf_wa;
	logic [31:0]           rf_wd;

	// fetch runs whenever the core is out of reset
	assign im_read = rst_n;

	assign ex_alu_b   = ex_use_imm ? ex_imm_ext : ex_rb_data;
	assign dm_address = {mem_alu_result[`CPU_DM_AW-1:2], 2'b00};
	assign dm_wdata   = mem_store_data;

	instruction_decoder u_decoder (
		.instruction (id_instr),
		.ra_addr     (id_ra_addr),
		.rb_addr     (id_rb_addr),
		.rt_addr     (id_rt_addr),
		.alu_op      (id_alu_op),
		.imm_ext     (id_imm_ext),
		.use_imm     (id_use_imm),
		.mem_read    (id_mem_read),
		.mem_write   (id_mem_write),
		.is_branch   (id_is_branch),
		.branch_ne   (id_branch_ne),
		.is_jump     (id_is_jump),
		.wb_src      (id_wb_src)
	);

	regfile u_regfile (
		.clk     (clk),
		.rst_n   (rst_n),
		.ra_addr (id_ra_addr),
		.rb_addr (id_rb_addr),
		.ra_data (id_ra_data),
		.rb_data (id_rb_data),
		.we      (rf_we),
		.wa      (rf_wa),
		.wd      (rf_wd)
	);

	alu u_alu (
		.a        (ex_ra_data),
		.b        (ex_alu_b),
		.shamt    (ex_shamt),
		.op       (ex_alu_op),
		.result   (ex_alu_result),
		.equal    (ex_equal),
		.overflow (ex_overflow)
	);

	branch_unit u_branch (
		.clk       (clk),
		.rst_n     (rst_n),
		.valid     (ex_valid),
		.is_branch (ex_is_branch),
		.branch_ne (ex_branch_ne),
		.is_jump   (ex_is_jump),
		.equal     (ex_equal),
		.ex_pc     (ex_pc),
		.offset    (ex_imm_ext),
		.pc        (im_address),
		.redirect  (redirect)
	);

	// stage signals share their names with the register ports
	pipe_regs u_pipe (
		.if_instr  (instruction),
		.if_pc     (im_address),
		.mem_read  (dm_read),
		.mem_write (dm_write),
		.*
	);

	writeback_stage u_writeback (
		.clk          (clk),
		.rst_n        (rst_n),
		.valid        (mem_valid),
		.wb_src       (mem_wb_src),
		.rt_addr      (mem_rt_addr),
		.alu_result   (mem_alu_result),
		.imm_ext      (mem_imm_ext),
		.mem_data     (dm_rdata),
		.ovf_update   (mem_ovf_update),
		.overflow     (mem_overflow),
		.we           (rf_we),
		.wa           (rf_wa),
		.wd           (rf_wd),
		.alu_overflow (alu_overflow)
	);

endmodule

// ==== verification/cpu_tb.sv ====
`include "cpu_cfg.svh"

module cpu_tb import cpu_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	logic                  clk;
	logic                  rst_n;
	logic [31:0]           instruction;
	logic                  im_read;
	logic [`CPU_IM_AW-1:0] im_address;
	logic                  dm_read;
	logic                  dm_write;
	logic [`CPU_DM_AW-1:0] dm_address;
	logic [31:0]           dm_wdata;
	logic [31:0]           dm_rdata;
	logic                  alu_overflow;

	logic [31:0] imem [1 << `CPU_IM_AW];
	logic [31:0] dmem [1 << (`CPU_DM_AW - 2)];
	logic [31:0] ref_mem [1 << (`CPU_DM_AW - 2)];

	// predicted stores in program order
	logic [`CPU_DM_AW-1:0] exp_addr [128];
	logic [31:0]           exp_data [128];
	logic                  exp_ovf [128];
	logic [`CPU_DM_AW-1:0] next_addr;
	logic [31:0]           next_data;
	logic                  next_ovf;
	int                    n_stores = 0;
	int                    store_idx = 0;
	int                    errors = 0;
	int                    prog_len = 0;

	cpu_top u_cpu_top (
		.clk          (clk),
		.rst_n        (rst_n),
		.instruction  (instruction),
		.im_read      (im_read),
		.im_address   (im_address),
		.dm_read      (dm_read),
		.dm_write     (dm_write),
		.dm_address   (dm_address),
		.dm_wdata     (dm_wdata),
		.dm_rdata     (dm_rdata),
		.alu_overflow (alu_overflow)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// both memories answer in the same cycle and only while read
	assign instruction = im_read ? imem[im_address] : '0;
	assign dm_rdata    = dm_read ? dmem[dm_address[`CPU_DM_AW-1:2]] : '0;

	always @(posedge clk) begin
		if (dm_write)
			dmem[dm_address[`CPU_DM_AW-1:2]] <= dm_wdata;
	end

	always @(posedge clk) begin
		if (rst_n && dm_write)
			store_idx <= store_idx + 1;
	end

	assign next_addr = exp_addr[store_idx];
	assign next_data = exp_data[store_idx];
	assign next_ovf  = exp_ovf[store_idx];

	store_count_check: assert property (@(posedge clk) disable iff (!rst_n)
		dm_write |-> store_idx < n_stores)
	else begin
		errors++;
		$display("unexpected store to %h after all %0d predicted stores",
			$sampled(dm_address), n_stores);
	end

	store_addr_check: assert property (@(posedge clk) disable iff (!rst_n)
		dm_write |-> dm_address == next_addr)
	else begin
		errors++;
		$display("Mismatch dm_address: got %h expected %h",
			$sampled(dm_address), $sampled(next_addr));
	end

	store_data_check: assert property (@(posedge clk) disable iff (!rst_n)
		dm_write |-> dm_wdata == next_data)
	else begin
		errors++;
		$display("Mismatch dm_wdata: got %h expected %h",
			$sampled(dm_wdata), $sampled(next_data));
	end

	// flag state as of the store with all older add, sub and addi included
	store_ovf_check: assert property (@(posedge clk) disable iff (!rst_n)
		dm_write |-> alu_overflow == next_ovf)
	else begin
		errors++;
		$display("Mismatch alu_overflow: got %h expected %h",
			$sampled(alu_overflow), $sampled(next_ovf));
	end

	task automatic expect_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		assert (got === want)
		else begin
			errors++;
			$display("Mismatch %s: got %h expected %h", name, got, want);
		end
	endtask

	function automatic logic [31:0] fill_word(input int i);
		return 32'h5a00_0000 ^ (i * 32'h0001_0203);
	endfunction

	function automatic logic [31:0] rr_word(input alu_sub_e sub, input int rt, input int ra,
			input int rb, input int sh);
		return {1'b0, ALU_R, 5'(rt), 5'(ra), 5'(rb), 5'(sh), sub};
	endfunction

	function automatic logic [31:0] imm_word(input opcode_e op, input int rt, input int ra,
			input logic [14:0] imm);
		return {1'b0, op, 5'(rt), 5'(ra), imm};
	endfunction

	function automatic logic [31:0] movi_word(input int rt, input logic [19:0] imm);
		return {1'b0, MOVI, 5'(rt), imm};
	endfunction

	function automatic logic [31:0] branch_word(input bit ne, input int ra, input int rt,
			input int off);
		return {1'b0, BR, 5'(rt), 5'(ra), ne, 14'(off)};
	endfunction

	function automatic logic [31:0] jump_word(input int off);
		return {1'b0, J, 1'b0, 24'(off)};
	endfunction

	task automatic emit(input logic [31:0] w);
		imem[prog_len] = w;
		prog_len++;
	endtask

	// two nops keep a consumer three slots behind its producer
	task automatic pad();
		emit(32'h0);
		emit(32'h0);
	endtask

	task automatic load_const(input int rt, input logic [31:0] value);
		emit(movi_word(rt, value[31:12]));
		pad();
		emit(rr_word(SUB_SLLI, rt, rt, 0, 12));
		pad();
		emit(imm_word(ORI, rt, rt, {3'b0, value[11:0]}));
		pad();
	endtask

	task automatic build_program();
		alu_sub_e    ops [8];
		logic [31:0] trap;
		ops = '{SUB_ADD, SUB_SUB, SUB_AND, SUB_OR, SUB_XOR, SUB_SLLI, SUB_SRLI, SUB_ROTRI};
		// squashed slots hold a store the model never predicts
		trap = imm_word(SWI, 1, 0, 15'd60);
		load_const(1, $urandom());
		load_const(2, $urandom());
		for (int k = 0; k < 8; k++) begin
			emit(rr_word(ops[k], 3, 1, 2, $urandom_range(31, 0)));
			pad();
			emit(imm_word(SWI, 3, 0, 15'(16 + k)));
		end
		// negative addi, ori with bit 14 set, negative movi
		emit(imm_word(ADDI, 4, 1, 15'($urandom()) | 15'h4000));
		emit(imm_word(ORI, 5, 0, 15'($urandom()) | 15'h4000));
		emit(movi_word(6, 20'($urandom()) | 20'h80000));
		pad();
		emit(imm_word(SWI, 4, 0, 15'd32));
		emit(imm_word(SWI, 5, 0, 15'd33));
		emit(imm_word(SWI, 6, 0, 15'd34));
		emit(imm_word(SWI, 1, 0, 15'd40));
		emit(imm_word(LWI, 7, 0, 15'd40));
		pad();
		emit(imm_word(SWI, 7, 0, 15'd41));
		emit(rr_word(SUB_OR, 8, 1, 0, 0));
		pad();
		emit(branch_word(0, 1, 8, 4));
		emit(trap);
		emit(trap);
		emit(trap);
		emit(imm_word(SWI, 2, 0, 15'd50));
		emit(branch_word(1, 1, 8, 4));
		emit(imm_word(SWI, 2, 0, 15'd51));
		emit(branch_word(1, 1, 2, 3));
		emit(trap);
		emit(trap);
		emit(imm_word(SWI, 1, 0, 15'd52));
		emit(branch_word(0, 1, 2, 3));
		emit(imm_word(SWI, 2, 0, 15'd53));
		emit(jump_word(3));
		emit(trap);
		emit(trap);
		emit(imm_word(SWI, 2, 0, 15'd55));
		load_const(9, 32'h7000_0000 | ($urandom() & 32'h0fff_ffff));
		emit(rr_word(SUB_SUB, 11, 1, 1, 0));
		emit(imm_word(SWI, 9, 0, 15'd69));
		emit(rr_word(SUB_ADD, 10, 9, 9, 0));
		emit(imm_word(SWI, 9, 0, 15'd70));
		emit(rr_word(SUB_SUB, 11, 1, 1, 0));
		emit(imm_word(SWI, 9, 0, 15'd71));
		// halt
		emit(jump_word(0));
	endtask

	task automatic run_model();
		logic [31:0] rf [32];
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] res;
		logic [31:0] addr;
		logic [31:0] off;
		logic [32:0] wide;
		logic [9:0]  pc;
		logic [9:0]  next_pc;
		logic        ovf;
		logic        has_res;
		logic        done;
		int          steps;
		for (int k = 0; k < 32; k++)
			rf[k] = '0;
		for (int k = 0; k < (1 << (`CPU_DM_AW - 2)); k++)
			ref_mem[k] = fill_word(k);
		pc = '0;
		ovf = 1'b0;
		done = 1'b0;
		steps = 0;
		while (!done && steps < 4000) begin
			w = imem[pc];
			a = rf[w[19:15]];
			b = rf[w[14:10]];
			res = '0;
			has_res = 1'b1;
			next_pc = pc + 1'b1;
			off = {{15{w[14]}}, w[14:0], 2'b00};
			case (w[30:25])
				ALU_R: begin
					case (w[4:0])
						SUB_ADD: begin
							wide = {a[31], a} + {b[31], b};
							res = wide[31:0];
							ovf = wide[32] ^ wide[31];
						end
						SUB_SUB: begin
							wide = {a[31], a} - {b[31], b};
							res = wide[31:0];
							ovf = wide[32] ^ wide[31];
						end
						SUB_AND:   res = a & b;
						SUB_OR:    res = a | b;
						SUB_XOR:   res = a ^ b;
						SUB_SLLI:  res = a << w[9:5];
						SUB_SRLI:  res = a >> w[9:5];
						SUB_ROTRI: res = (a >> w[9:5]) | (a << (32 - w[9:5]));
						default:   has_res = 1'b0;
					endcase
				end
				ADDI: begin
					b = {{17{w[14]}}, w[14:0]};
					wide = {a[31], a} + {b[31], b};
					res = wide[31:0];
					ovf = wide[32] ^ wide[31];
				end
				ORI:  res = a | {17'b0, w[14:0]};
				MOVI: res = {{12{w[19]}}, w[19:0]};
				LWI: begin
					addr = a + off;
					res = ref_mem[addr[`CPU_DM_AW-1:2]];
				end
				SWI: begin
					has_res = 1'b0;
					addr = a + off;
					ref_mem[addr[`CPU_DM_AW-1:2]] = rf[w[24:20]];
					exp_addr[n_stores] = {addr[`CPU_DM_AW-1:2], 2'b00};
					exp_data[n_stores] = rf[w[24:20]];
					exp_ovf[n_stores] = ovf;
					n_stores++;
				end
				// offsets wrap within the 10-bit word address
				BR: begin
					has_res = 1'b0;
					if ((a == rf[w[24:20]]) != w[14])
						next_pc = pc + w[9:0];
				end
				J: begin
					has_res = 1'b0;
					if (w[23:0] == '0)
						done = 1'b1;
					else
						next_pc = pc + w[9:0];
				end
				default: has_res = 1'b0;
			endcase
			if (has_res && w[24:20] != 5'd0)
				rf[w[24:20]] = res;
			pc = next_pc;
			steps++;
		end
	endtask

	initial begin
		int cycles;
		logic timed_out;
		rst_n = 1'b0;
		void'($urandom(32'h2b59afc4));
		for (int k = 0; k < (1 << `CPU_IM_AW); k++)
			imem[k] = 32'(k);
		for (int k = 0; k < (1 << (`CPU_DM_AW - 2)); k++)
			dmem[k] = fill_word(k);
		build_program();
		run_model();
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		#1;
		expect_value("im_address", 32'(im_address), 32'h0);
		expect_value("dm_read", 32'(dm_read), 32'h0);
		expect_value("dm_write", 32'(dm_write), 32'h0);
		expect_value("alu_overflow", 32'(alu_overflow), 32'h0);
		expect_value("im_read", 32'(im_read), 32'h1);
		cycles = 0;
		while (store_idx < n_stores && cycles < 5000) begin
			@(negedge clk);
			cycles++;
		end
		timed_out = store_idx < n_stores;
		if (timed_out) begin
			$display("timeout waiting for the predicted stores");
		end else begin
			// the halt loop must stay quiet
			repeat (20) @(negedge clk);
			for (int k = 0; k < (1 << (`CPU_DM_AW - 2)); k++)
				expect_value($sformatf("dmem[%0d]", k), dmem[k], ref_mem[k]);
		end
		$display("%0d errors, %0d of %0d predicted stores seen", errors, store_idx, n_stores);
		if (errors == 0 && !timed_out)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== cpu.f ====
+incdir+rtl
rtl/cpu_pkg.sv
rtl/instruction_decoder.sv
rtl/regfile.sv
rtl/alu.sv
rtl/branch_unit.sv
rtl/pipe_regs.sv
rtl/writeback_stage.sv
rtl/cpu_top.sv
verification/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cpu_pkg.sv
      - rtl/instruction_decoder.sv
      - rtl/regfile.sv
      - rtl/alu.sv
      - rtl/branch_unit.sv
      - rtl/pipe_regs.sv
      - rtl/writeback_stage.sv
      - rtl/cpu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verification/cpu_tb.sv
